// ==== source/arch_defs_pkg.sv ====
package arch_defs_pkg;

    // ====================
    // Bus data path
    // ====================
    localparam int DATA_WIDTH = 8;

    // Register map, one byte per offset
    typedef enum logic [1:0] {
        UART_REG_CONFIG  = 2'd0,
        UART_REG_STATUS  = 2'd1,
        UART_REG_DATA    = 2'd2,
        UART_REG_COMMAND = 2'd3
    } uart_reg_offset_e;

    // One CPU register access, 13 bits wide
    typedef struct packed {
        logic                  enable;
        logic                  write;
        logic                  read;
        uart_reg_offset_e      offset;
        logic [DATA_WIDTH-1:0] wdata;
    } uart_bus_req_t;

endpackage

// ==== source/uart_pkg.sv ====
package uart_pkg;

    // ====================
    // Frame format
    // ====================
    // 8N1 with 16 ticks per bit
    localparam int UART_OVERSAMPLE = 16;
    localparam int UART_DATA_BITS  = 8;

    // Start bit is confirmed half a bit after the falling edge
    localparam int UART_START_CONFIRM = UART_OVERSAMPLE / 2;

    // ====================
    // Register bit fields
    // ====================
    // Status word, upper bits read as zero
    localparam int STATUS_TX_EMPTY_BIT    = 0;
    localparam int STATUS_RX_READY_BIT    = 1;
    localparam int STATUS_FRAME_ERR_BIT   = 2;
    localparam int STATUS_OVERRUN_ERR_BIT = 3;

    // Command word, write 1 to clear
    localparam int CMD_CLEAR_FRAME_ERR_BIT   = 0;
    localparam int CMD_CLEAR_OVERRUN_ERR_BIT = 1;

    // One-cycle error pulses from the receiver
    typedef struct packed {
        logic frame;
        logic overrun;
    } uart_rx_err_t;

endpackage

// ==== source/uart_baud_gen.sv ====
`timescale 1ns/1ps

module uart_baud_gen #(
    parameter int CLKS_PER_TICK = 4
) (
    input  logic clk,
    input  logic reset,
    output logic tick_o
);

    // Keep the counter at least one bit wide for a divide-by-one
    localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_TICK - 1);

    logic [CNT_W-1:0] clk_cnt;

    // Free-running divider, tick on wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_cnt <= '0;
            tick_o  <= 1'b0;
        end else begin
            if (clk_cnt == CNT_LAST) begin
                clk_cnt <= '0;
                tick_o  <= 1'b1;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
                tick_o  <= 1'b0;
            end
        end
    end

endmodule

// ==== source/uart_receiver.sv ====
`timescale 1ns/1ps

module uart_receiver (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 tick_i,
    input  logic                                 serial_rx_i,
    input  logic                                 read_ack_i,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] rx_data_o,
    output logic                                 rx_ready_o,
    output uart_pkg::uart_rx_err_t               rx_err_o
);

    localparam int TICK_W = $clog2(uart_pkg::UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(uart_pkg::UART_DATA_BITS);

    localparam logic [TICK_W-1:0] TICK_LAST  = TICK_W'(uart_pkg::UART_OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] TICK_START = TICK_W'(uart_pkg::UART_START_CONFIRM - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST   = BIT_W'(uart_pkg::UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e                             state;
    logic      [1:0]                       rx_sync;
    logic                                  rx_line;
    logic      [TICK_W-1:0]                tick_cnt;
    logic      [BIT_W-1:0]                 bit_cnt;
    logic      [arch_defs_pkg::DATA_WIDTH-1:0] shift_reg;

    // ====================
    // Input synchronizer
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], serial_rx_i};
        end
    end

    assign rx_line = rx_sync[1];

    // ====================
    // Frame FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= RX_IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            rx_ready_o <= 1'b0;
            rx_err_o   <= '0;
        end else begin
            rx_err_o <= '0;

            // CPU took the byte
            if (read_ack_i) begin
                rx_ready_o <= 1'b0;
            end

            if (tick_i) begin
                case (state)
                    RX_IDLE: begin
                        tick_cnt <= '0;
                        if (!rx_line) begin
                            state <= RX_START;
                        end
                    end

                    RX_START: begin
                        if (tick_cnt == TICK_START) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            // Glitch on the line, go back to waiting
                            state    <= rx_line ? RX_IDLE : RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end

                    RX_DATA: begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            // LSB first, shift in from the top
                            shift_reg <= {rx_line, shift_reg[arch_defs_pkg::DATA_WIDTH-1:1]};
                            if (bit_cnt == BIT_LAST) begin
                                state <= RX_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end

                    RX_STOP: begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            state    <= RX_IDLE;
                            if (!rx_line) begin
                                rx_err_o.frame <= 1'b1;
                            end else if (rx_ready_o && !read_ack_i) begin
                                // Old byte still unread, keep it
                                rx_err_o.overrun <= 1'b1;
                            end else begin
                                rx_data_o  <= shift_reg;
                                rx_ready_o <= 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end

                    default: begin
                        state <= RX_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 tick_i,
    input  logic                                 start_i,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] tx_data_i,
    output logic                                 busy_o,
    output logic                                 serial_tx_o
);

    localparam int TICK_W = $clog2(uart_pkg::UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(uart_pkg::UART_DATA_BITS);

    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(uart_pkg::UART_OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(uart_pkg::UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e                                 state;
    logic      [TICK_W-1:0]                    tick_cnt;
    logic      [BIT_W-1:0]                     bit_cnt;
    logic      [arch_defs_pkg::DATA_WIDTH-1:0] shift_reg;

    // ====================
    // Frame sequencer
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    // Start while busy never reaches here
                    if (start_i) begin
                        shift_reg <= tx_data_i;
                        tick_cnt  <= '0;
                        bit_cnt   <= '0;
                        state     <= TX_START;
                    end
                end

                TX_START: begin
                    if (tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == TICK_LAST) begin
                            state <= TX_DATA;
                        end
                    end
                end

                TX_DATA: begin
                    if (tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == TICK_LAST) begin
                            shift_reg <= shift_reg >> 1;
                            bit_cnt   <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_LAST) begin
                                state <= TX_STOP;
                            end
                        end
                    end
                end

                TX_STOP: begin
                    if (tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == TICK_LAST) begin
                            state <= TX_IDLE;
                        end
                    end
                end

                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Line level per state, idle and stop are high
    always_comb begin
        case (state)
            TX_START: serial_tx_o = 1'b0;
            TX_DATA:  serial_tx_o = shift_reg[0];
            default:  serial_tx_o = 1'b1;
        endcase
    end

    assign busy_o = (state != TX_IDLE);

endmodule

// ==== source/uart_peripheral.sv ====
`timescale 1ns/1ps

module uart_peripheral #(
    parameter int CLKS_PER_TICK = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  arch_defs_pkg::uart_bus_req_t         bus_req_i,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] rdata_o,
    input  logic                                 serial_rx_i,
    output logic                                 serial_tx_o
);

    localparam int DW = arch_defs_pkg::DATA_WIDTH;

    logic                   tick;
    logic                   wr_access;
    logic                   rd_access;
    logic                   data_rd;
    logic                   data_rd_dly;
    logic                   read_ack;
    logic                   tx_start;
    logic                   tx_busy;
    logic [DW-1:0]          rx_data;
    logic                   rx_ready;
    uart_pkg::uart_rx_err_t rx_err;
    logic [DW-1:0]          config_reg;
    logic [DW-1:0]          status_word;
    logic                   frame_err_flag;
    logic                   overrun_err_flag;
    logic                   clear_frame_err;
    logic                   clear_overrun_err;

    // ====================
    // Access decode
    // ====================
    // Write takes priority if both strobes are set
    assign wr_access = bus_req_i.enable && bus_req_i.write;
    assign rd_access = bus_req_i.enable && bus_req_i.read && !bus_req_i.write;

    assign tx_start = wr_access && (bus_req_i.offset == arch_defs_pkg::UART_REG_DATA);
    assign data_rd  = rd_access && (bus_req_i.offset == arch_defs_pkg::UART_REG_DATA);

    assign clear_frame_err = wr_access
        && (bus_req_i.offset == arch_defs_pkg::UART_REG_COMMAND)
        && bus_req_i.wdata[uart_pkg::CMD_CLEAR_FRAME_ERR_BIT];
    assign clear_overrun_err = wr_access
        && (bus_req_i.offset == arch_defs_pkg::UART_REG_COMMAND)
        && bus_req_i.wdata[uart_pkg::CMD_CLEAR_OVERRUN_ERR_BIT];

    // Acknowledge only the first cycle of a data read
    always_ff @(posedge clk) begin
        if (reset) begin
            data_rd_dly <= 1'b0;
        end else begin
            data_rd_dly <= data_rd;
        end
    end

    assign read_ack = data_rd && !data_rd_dly;

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            config_reg       <= '0;
            frame_err_flag   <= 1'b0;
            overrun_err_flag <= 1'b0;
        end else begin
            if (wr_access && (bus_req_i.offset == arch_defs_pkg::UART_REG_CONFIG)) begin
                config_reg <= bus_req_i.wdata;
            end

            // Sticky flags, a clear beats a set in the same cycle
            if (clear_frame_err) begin
                frame_err_flag <= 1'b0;
            end else if (rx_err.frame) begin
                frame_err_flag <= 1'b1;
            end

            if (clear_overrun_err) begin
                overrun_err_flag <= 1'b0;
            end else if (rx_err.overrun) begin
                overrun_err_flag <= 1'b1;
            end
        end
    end

    always_comb begin
        status_word = '0;
        status_word[uart_pkg::STATUS_TX_EMPTY_BIT]    = !tx_busy;
        status_word[uart_pkg::STATUS_RX_READY_BIT]    = rx_ready;
        status_word[uart_pkg::STATUS_FRAME_ERR_BIT]   = frame_err_flag;
        status_word[uart_pkg::STATUS_OVERRUN_ERR_BIT] = overrun_err_flag;
    end

    // Read mux, zero outside a read
    always_comb begin
        rdata_o = '0;
        if (rd_access) begin
            case (bus_req_i.offset)
                arch_defs_pkg::UART_REG_CONFIG: rdata_o = config_reg;
                arch_defs_pkg::UART_REG_STATUS: rdata_o = status_word;
                arch_defs_pkg::UART_REG_DATA:   rdata_o = rx_data;
                default:                        rdata_o = '0;
            endcase
        end
    end

    // ====================
    // Serial blocks
    // ====================
    uart_baud_gen #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) u_baud_gen (
        .clk   (clk),
        .reset (reset),
        .tick_o(tick)
    );

    uart_receiver u_receiver (
        .clk        (clk),
        .reset      (reset),
        .tick_i     (tick),
        .serial_rx_i(serial_rx_i),
        .read_ack_i (read_ack),
        .rx_data_o  (rx_data),
        .rx_ready_o (rx_ready),
        .rx_err_o   (rx_err)
    );

    uart_transmitter u_transmitter (
        .clk        (clk),
        .reset      (reset),
        .tick_i     (tick),
        .start_i    (tx_start),
        .tx_data_i  (bus_req_i.wdata),
        .busy_o     (tx_busy),
        .serial_tx_o(serial_tx_o)
    );

endmodule

// ==== test/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;

    localparam int DW            = arch_defs_pkg::DATA_WIDTH;
    localparam int CLK_PERIOD    = 40;
    localparam int CLKS_PER_TICK = 4;
    localparam int BIT_CLKS      = CLKS_PER_TICK * uart_pkg::UART_OVERSAMPLE;
    localparam int WAIT_LIMIT    = 4 * BIT_CLKS;

    typedef enum logic [1:0] {
        ACT_SEND_RX,
        ACT_WRITE_TX,
        ACT_READ_REG,
        ACT_WRITE_REG
    } action_e;

    // One table row, stop_ok only matters for ACT_SEND_RX
    typedef struct packed {
        action_e                          act;
        arch_defs_pkg::uart_reg_offset_e  offset;
        logic [DW-1:0]                    data;
        logic                             stop_ok;
        logic [DW-1:0]                    expected;
    } step_t;

    logic                         clk;
    logic                         reset;
    arch_defs_pkg::uart_bus_req_t bus_req;
    logic [DW-1:0]                rdata;
    logic                         serial_rx;
    logic                         serial_tx;
    integer                       seed;
    step_t                        steps[$];

    uart_peripheral #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .bus_req_i  (bus_req),
        .rdata_o    (rdata),
        .serial_rx_i(serial_rx),
        .serial_tx_o(serial_tx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Checks
    // ====================
    task automatic check_value(string name, logic [DW-1:0] actual, logic [DW-1:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = 8'h%h, expected 8'h%h",
                     $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_abort(string what);
        $display("Timeout at %0t ns: %s did not happen in time", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "wait timed out");
    endtask

    function automatic logic [DW-1:0] bit_mask(int pos);
        return DW'(1) << pos;
    endfunction

    // ====================
    // Bus and line models
    // ====================
    task automatic write_reg(arch_defs_pkg::uart_reg_offset_e off, logic [DW-1:0] data);
        @(negedge clk);
        bus_req.enable = 1'b1;
        bus_req.write  = 1'b1;
        bus_req.offset = off;
        bus_req.wdata  = data;
        @(negedge clk);
        bus_req = '0;
    endtask

    // rdata is combinational, sampled in the middle of the low phase
    task automatic read_reg(arch_defs_pkg::uart_reg_offset_e off, output logic [DW-1:0] value);
        @(negedge clk);
        bus_req.enable = 1'b1;
        bus_req.read   = 1'b1;
        bus_req.offset = off;
        #(CLK_PERIOD / 4);
        value = rdata;
        @(negedge clk);
        bus_req = '0;
    endtask

    task automatic wait_status(logic [DW-1:0] mask, logic [DW-1:0] want, string what);
        logic [DW-1:0] status;
        logic          done;
        done = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !done; i++) begin
            read_reg(arch_defs_pkg::UART_REG_STATUS, status);
            done = ((status & mask) == want);
        end
        if (!done) begin
            timeout_abort(what);
        end
    endtask

    // Frame into the receiver, LSB first, then one idle bit
    task automatic send_frame(logic [DW-1:0] data, logic stop_ok);
        logic [DW-1:0] shift;
        shift = data;
        serial_rx = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (int b = 0; b < uart_pkg::UART_DATA_BITS; b++) begin
            serial_rx = shift[0];
            shift = shift >> 1;
            repeat (BIT_CLKS) @(negedge clk);
        end
        // Short bad stop so the receiver does not see a new start bit
        serial_rx = stop_ok;
        repeat (3 * BIT_CLKS / 4) @(negedge clk);
        serial_rx = 1'b1;
        repeat (BIT_CLKS + BIT_CLKS / 4) @(negedge clk);
    endtask

    task automatic capture_tx(output logic [DW-1:0] value);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
            @(negedge clk);
            seen = !serial_tx;
        end
        if (!seen) begin
            timeout_abort("start bit on serial_tx_o");
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        check_value("serial_tx_o start bit", DW'(serial_tx), '0);
        value = '0;
        for (int b = 0; b < uart_pkg::UART_DATA_BITS; b++) begin
            repeat (BIT_CLKS) @(negedge clk);
            value = {serial_tx, value[DW-1:1]};
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_value("serial_tx_o stop bit", DW'(serial_tx), DW'(1));
    endtask

    // ====================
    // Table
    // ====================
    function automatic void add_step(action_e act, arch_defs_pkg::uart_reg_offset_e off,
                                     logic [DW-1:0] data, logic stop_ok,
                                     logic [DW-1:0] expected);
        step_t st;
        st.act      = act;
        st.offset   = off;
        st.data     = data;
        st.stop_ok  = stop_ok;
        st.expected = expected;
        steps.push_back(st);
    endfunction

    task automatic apply_step(step_t st);
        logic [DW-1:0] value;
        logic [DW-1:0] wait_bit;
        case (st.act)
            ACT_SEND_RX: begin
                send_frame(st.data, st.stop_ok);
                wait_bit = st.stop_ok ? bit_mask(uart_pkg::STATUS_RX_READY_BIT)
                                      : bit_mask(uart_pkg::STATUS_FRAME_ERR_BIT);
                wait_status(wait_bit, wait_bit, "receive status bit set");
            end
            ACT_WRITE_TX: begin
                write_reg(arch_defs_pkg::UART_REG_DATA, st.data);
                read_reg(arch_defs_pkg::UART_REG_STATUS, value);
                check_value("status tx_empty while busy",
                            value & bit_mask(uart_pkg::STATUS_TX_EMPTY_BIT), '0);
                // Must be dropped by the busy transmitter
                write_reg(arch_defs_pkg::UART_REG_DATA, ~st.data);
                capture_tx(value);
                check_value("serial_tx_o byte", value, st.expected);
                wait_status(bit_mask(uart_pkg::STATUS_TX_EMPTY_BIT),
                            bit_mask(uart_pkg::STATUS_TX_EMPTY_BIT), "transmitter idle");
                repeat (2 * BIT_CLKS) begin
                    @(negedge clk);
                    check_value("serial_tx_o idle", DW'(serial_tx), DW'(1));
                end
            end
            ACT_READ_REG: begin
                read_reg(st.offset, value);
                check_value($sformatf("rdata_o at offset %0d", st.offset), value, st.expected);
            end
            ACT_WRITE_REG: begin
                write_reg(st.offset, st.data);
            end
        endcase
    endtask

    initial begin
        logic [31:0]   rnd;
        logic [DW-1:0] payload;

        clk       = 1'b0;
        reset     = 1'b1;
        bus_req   = '0;
        serial_rx = 1'b1;
        seed      = 32'h4a8b;

        // Reset values and config storage
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h01);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_CONFIG, 8'h00, 1'b1, 8'h00);
        add_step(ACT_WRITE_REG, arch_defs_pkg::UART_REG_CONFIG, 8'h5a, 1'b1, 8'h00);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_CONFIG, 8'h00, 1'b1, 8'h5a);
        // Transmit, then receive one good byte
        add_step(ACT_WRITE_TX, arch_defs_pkg::UART_REG_DATA, 8'ha5, 1'b1, 8'ha5);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h01);
        add_step(ACT_SEND_RX, arch_defs_pkg::UART_REG_DATA, 8'h3c, 1'b1, 8'h00);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h03);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_DATA, 8'h00, 1'b1, 8'h3c);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h01);
        // Frame error and its clear
        add_step(ACT_SEND_RX, arch_defs_pkg::UART_REG_DATA, 8'hc3, 1'b0, 8'h00);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h05);
        add_step(ACT_WRITE_REG, arch_defs_pkg::UART_REG_COMMAND, 8'h01, 1'b1, 8'h00);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h01);
        // Overrun keeps the first byte
        add_step(ACT_SEND_RX, arch_defs_pkg::UART_REG_DATA, 8'h11, 1'b1, 8'h00);
        add_step(ACT_SEND_RX, arch_defs_pkg::UART_REG_DATA, 8'h22, 1'b1, 8'h00);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h0b);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_DATA, 8'h00, 1'b1, 8'h11);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h09);
        add_step(ACT_WRITE_REG, arch_defs_pkg::UART_REG_COMMAND, 8'h02, 1'b1, 8'h00);
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h01);

        // Random payloads both ways
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            payload = rnd[DW-1:0];
            add_step(ACT_SEND_RX, arch_defs_pkg::UART_REG_DATA, payload, 1'b1, 8'h00);
            add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_DATA, 8'h00, 1'b1, payload);
            add_step(ACT_WRITE_TX, arch_defs_pkg::UART_REG_DATA, payload, 1'b1, payload);
        end
        add_step(ACT_READ_REG, arch_defs_pkg::UART_REG_STATUS, 8'h00, 1'b1, 8'h01);

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            apply_step(steps[i]);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== build.f ====
source/arch_defs_pkg.sv
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/uart_peripheral.sv
test/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module uart_tb -o uart_tb_sim

# A failing run ends in $fatal, which gives a non-zero exit status
./obj_dir/uart_tb_sim
